/* rtl/piton_pkg.sv */
// L1.5 message encodings and port structs, imported by the bridge, the cache model and the top level
package piton_pkg;

    // request types, sized to the 6-bit rqtype field
    typedef enum logic [5:0] {
        LOAD_RQ  = 6'd0,
        STORE_RQ = 6'd1
    } l15_rqtype_e;

    // return types seen on the response channel
    typedef enum logic [3:0] {
        LOAD_RET = 4'd0,
        ST_ACK   = 4'd4,
        INT_RET  = 4'd7
    } l15_rettype_e;

    // message data size codes
    typedef enum logic [2:0] {
        SIZE_0B = 3'd0,
        SIZE_1B = 3'd1,
        SIZE_2B = 3'd2,
        SIZE_4B = 3'd3
    } l15_size_e;

    // request from the bridge to the L1.5, data in big-endian lanes
    typedef struct packed {
        l15_rqtype_e rqtype;
        l15_size_e   size;
        logic [31:0] address;
        logic [31:0] data;
    } l15_req_t;

    // response from the L1.5 to the bridge
    typedef struct packed {
        l15_rettype_e returntype;
        logic [31:0]  data_0;
    } l15_rsp_t;

endpackage

/* rtl/core_mem_pkg.sv */
// core memory-stage opcodes and port structs, imported wherever the core side of the bridge is seen
package core_mem_pkg;

    // memory-stage operation
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    // one core access, wdata in little-endian lanes
    // byte_en bit k enables the byte at address offset k
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } core_mem_req_t;

    // load data back to the core, little-endian lanes
    typedef struct packed {
        logic [31:0] rdata;
    } core_mem_rsp_t;

endpackage

/* rtl/core_piton.sv */
// bridge from the core memory port to an L1.5 cache port, one access in flight at a time
`timescale 1ns/1ps

module core_piton (
    input  logic                       clk,
    input  logic                       nrst,
    // core side
    input  core_mem_pkg::core_mem_req_t req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output core_mem_pkg::core_mem_rsp_t rsp,
    output logic                       rsp_valid,
    // L1.5 side
    output piton_pkg::l15_req_t        l15_req,
    output logic                       l15_val,
    input  logic                       header_ack,
    input  logic                       ack,
    input  piton_pkg::l15_rsp_t        l15_rsp,
    input  logic                       l15_rsp_val,
    output logic                       req_ack
);
    import piton_pkg::*;
    import core_mem_pkg::*;

    typedef enum logic [1:0] {
        S_REQ,
        S_IDLE,
        S_RESP
    } state_e;

    state_e       state;
    l15_rqtype_e  rqtype_q;
    l15_rettype_e exp_ret;
    logic [31:0]  rdata_q;
    logic         accept;
    logic         rsp_take;

    // little-endian core lanes to big-endian L1.5 lanes and back
    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // store size code from the byte enables
    function automatic l15_size_e size_from_be(input logic [3:0] be);
        l15_size_e sz;
        case (be)
            4'b1111: sz = SIZE_4B;
            4'b0011,
            4'b1100: sz = SIZE_2B;
            4'b0001,
            4'b0010,
            4'b0100,
            4'b1000: sz = SIZE_1B;
            // holes or misaligned runs are not expressible
            default: sz = SIZE_0B;
        endcase
        return sz;
    endfunction

    // outgoing request fields
    always_comb begin
        l15_req.address = req.addr;
        l15_req.data    = swap_bytes(req.wdata);
        if (req.op == MEM_STORE) begin
            l15_req.rqtype = STORE_RQ;
            l15_req.size   = size_from_be(req.byte_en);
        end else begin
            l15_req.rqtype = LOAD_RQ;
            l15_req.size   = SIZE_4B;
        end
    end

    assign l15_val   = (state == S_REQ) && req_valid;
    assign accept    = l15_val && header_ack && ack;
    assign req_ready = accept;

    // only the return type that answers the stored request completes it
    assign exp_ret  = (rqtype_q == STORE_RQ) ? ST_ACK : LOAD_RET;
    assign req_ack  = (state == S_IDLE) && l15_rsp_val;
    assign rsp_take = req_ack && (l15_rsp.returntype == exp_ret);

    assign rsp_valid = (state == S_RESP);
    assign rsp.rdata = rdata_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= S_REQ;
            rqtype_q <= LOAD_RQ;
        end else begin
            case (state)
                S_REQ: begin
                    if (accept) begin
                        state    <= S_IDLE;
                        rqtype_q <= l15_req.rqtype;
                    end
                end
                S_IDLE: begin
                    // mismatched returns are acked and dropped
                    if (rsp_take) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    state <= S_REQ;
                end
                default: begin
                    state <= S_REQ;
                end
            endcase
        end
    end

    // load data held for the rsp_valid cycle
    always_ff @(posedge clk) begin
        if (rsp_take) begin
            rdata_q <= swap_bytes(l15_rsp.data_0);
        end
    end

endmodule

/* rtl/l15_mem_model.sv */
// synthesizable L1.5 stand-in, a big-endian byte memory answering after a fixed latency
`timescale 1ns/1ps

module l15_mem_model #(
    parameter int MEM_WORDS   = 64,
    parameter int RSP_LATENCY = 3
) (
    input  logic                clk,
    input  logic                nrst,
    input  piton_pkg::l15_req_t l15_req,
    input  logic                l15_val,
    output logic                header_ack,
    output logic                ack,
    output piton_pkg::l15_rsp_t l15_rsp,
    output logic                l15_rsp_val,
    input  logic                req_ack
);
    import piton_pkg::*;

    localparam int AW = $clog2(MEM_WORDS * 4);
    localparam int CW = (RSP_LATENCY > 1) ? $clog2(RSP_LATENCY) : 1;

    typedef enum logic {
        M_IDLE,
        M_BUSY
    } state_e;

    state_e        state;
    logic [CW-1:0] lat_cnt;
    l15_req_t      req_q;
    logic [7:0]    mem [MEM_WORDS*4];
    logic          accept;
    logic [3:0]    wr_mask;
    logic [AW-3:0] wr_word;
    logic [AW-3:0] rd_word;

    // ready only with nothing outstanding
    assign header_ack = (state == M_IDLE);
    assign ack        = (state == M_IDLE);
    assign accept     = l15_val && header_ack && ack;

    assign l15_rsp_val = (state == M_BUSY) && (lat_cnt == '0);

    assign wr_word = l15_req.address[AW-1:2];
    assign rd_word = req_q.address[AW-1:2];

    // byte lanes touched by a store, bit k is word offset k
    always_comb begin
        case (l15_req.size)
            SIZE_1B: wr_mask = 4'b0001 << l15_req.address[1:0];
            SIZE_2B: wr_mask = 4'b0011 << l15_req.address[1:0];
            SIZE_4B: wr_mask = 4'b1111;
            default: wr_mask = 4'b0000;
        endcase
    end

    // stores land at the acceptance edge
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < MEM_WORDS * 4; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (accept && (l15_req.rqtype == STORE_RQ)) begin
            for (int k = 0; k < 4; k++) begin
                if (wr_mask[k]) begin
                    // offset k sits in the k-th lane from the top
                    mem[{wr_word, 2'(k)}] <= l15_req.data[31-8*k -: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= l15_req;
        end
    end

    // response built from the held request
    always_comb begin
        l15_rsp.returntype = (req_q.rqtype == STORE_RQ) ? ST_ACK : LOAD_RET;
        l15_rsp.data_0     = {mem[{rd_word, 2'd0}],
                              mem[{rd_word, 2'd1}],
                              mem[{rd_word, 2'd2}],
                              mem[{rd_word, 2'd3}]};
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= M_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (accept) begin
                        state   <= M_BUSY;
                        lat_cnt <= CW'(RSP_LATENCY - 1);
                    end
                end
                M_BUSY: begin
                    // count down, then hold the response until acked
                    if (lat_cnt != '0) begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end else if (req_ack) begin
                        state <= M_IDLE;
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/piton_mem_subsys.sv */
// top level joining the core-to-L1.5 bridge with the L1.5 memory model
`timescale 1ns/1ps

module piton_mem_subsys #(
    parameter int MEM_WORDS   = 64,
    parameter int RSP_LATENCY = 3
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  core_mem_pkg::core_mem_req_t req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output core_mem_pkg::core_mem_rsp_t rsp,
    output logic                       rsp_valid
);
    import piton_pkg::*;

    // L1.5 port between bridge and model
    l15_req_t l15_req;
    logic     l15_val;
    logic     header_ack;
    logic     ack;
    l15_rsp_t l15_rsp;
    logic     l15_rsp_val;
    logic     req_ack;

    core_piton u_bridge (
        .clk         (clk),
        .nrst        (nrst),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .l15_req     (l15_req),
        .l15_val     (l15_val),
        .header_ack  (header_ack),
        .ack         (ack),
        .l15_rsp     (l15_rsp),
        .l15_rsp_val (l15_rsp_val),
        .req_ack     (req_ack)
    );

    l15_mem_model #(
        .MEM_WORDS   (MEM_WORDS),
        .RSP_LATENCY (RSP_LATENCY)
    ) u_l15 (
        .clk         (clk),
        .nrst        (nrst),
        .l15_req     (l15_req),
        .l15_val     (l15_val),
        .header_ack  (header_ack),
        .ack         (ack),
        .l15_rsp     (l15_rsp),
        .l15_rsp_val (l15_rsp_val),
        .req_ack     (req_ack)
    );

endmodule

/* verification/tb_piton_mem_subsys.sv */
// testbench for the core-to-L1.5 subsystem, built and run by the Makefile through Verilator
`timescale 1ns/1ps

module tb_piton_mem_subsys;
    import core_mem_pkg::*;

    localparam int MEM_WORDS   = 64;
    localparam int RSP_LATENCY = 3;
    localparam int AW          = $clog2(MEM_WORDS * 4);
    localparam int N_REQ       = 100;
    localparam int CYCLE_LIMIT = 40 * N_REQ + 100;

    logic          clk;
    logic          nrst;
    core_mem_req_t req;
    logic          req_valid;
    logic          req_ready;
    core_mem_rsp_t rsp;
    logic          rsp_valid;

    // little-endian byte image of the memory behind the bridge
    logic [7:0]  ref_mem [MEM_WORDS*4];
    int          errors;
    int          issue_cnt;
    int          acc_cnt;
    int          cycle_cnt;
    logic        busy;
    int          age;
    logic        exp_load;
    logic [31:0] exp_rdata;

    piton_mem_subsys #(
        .MEM_WORDS   (MEM_WORDS),
        .RSP_LATENCY (RSP_LATENCY)
    ) u_dut (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // outstanding request, age counts cycles since acceptance
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy    <= 1'b0;
            age     <= 0;
            acc_cnt <= 0;
        end else if (req_valid && req_ready) begin
            busy    <= 1'b1;
            age     <= 1;
            acc_cnt <= acc_cnt + 1;
        end else if (busy) begin
            if (rsp_valid) begin
                busy <= 1'b0;
            end else begin
                age <= age + 1;
            end
        end
    end

    // checks sampled mid-cycle, away from both edges
    a_reset_quiet: assert property (@(negedge clk) nrst || (!req_ready && !rsp_valid))
        else begin
            errors++;
            $display("** Error: req_ready = %h, rsp_valid = %h in reset, expected 0 0",
                     req_ready, rsp_valid);
        end

    a_one_at_a_time: assert property (@(negedge clk) disable iff (!nrst) !(busy && req_ready))
        else begin
            errors++;
            $display("** Error: req_ready = %h while busy, expected %h", req_ready, 1'b0);
        end

    a_rsp_timing: assert property (@(negedge clk) disable iff (!nrst)
                                   rsp_valid == (busy && (age == RSP_LATENCY + 1)))
        else begin
            errors++;
            $display("** Error: rsp_valid = %h at age %h, expected pulse at age %h",
                     rsp_valid, age, RSP_LATENCY + 1);
        end

    a_taken_once: assert property (@(negedge clk) disable iff (!nrst) acc_cnt <= issue_cnt)
        else begin
            errors++;
            $display("** Error: acc_cnt = %h, expected at most %h", acc_cnt, issue_cnt);
        end

    a_load_data: assert property (@(negedge clk) disable iff (!nrst)
                                  !(rsp_valid && exp_load) || (rsp.rdata == exp_rdata))
        else begin
            errors++;
            $display("** Error: rsp.rdata = %h, expected %h", rsp.rdata, exp_rdata);
        end

    // patterns that map onto an L1.5 size code
    function automatic logic be_writes(input logic [3:0] be);
        case (be)
            4'b1111, 4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int low_offset(input logic [3:0] be);
        int off;
        off = 0;
        for (int k = 3; k >= 0; k--) begin
            if (be[k]) begin
                off = k;
            end
        end
        return off;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        int b;
        b = int'({addr[AW-1:2], 2'b00});
        return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
    endfunction

    function automatic void ref_store(input logic [31:0] addr, input logic [31:0] wdata,
                                      input logic [3:0] be);
        int b;
        b = int'({addr[AW-1:2], 2'b00});
        if (be_writes(be)) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    ref_mem[b+k] = wdata[8*k +: 8];
                end
            end
        end
    endfunction

    task automatic present(input mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be);
        req.op      = op;
        req.addr    = addr;
        req.wdata   = wdata;
        req.byte_en = be;
        req_valid   = 1'b1;
        issue_cnt++;
        exp_load    = (op == MEM_LOAD);
        exp_rdata   = ref_word(addr);
    endtask

    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = req_valid && req_ready;
        end
        #2;
    endtask

    task automatic wait_response();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = rsp_valid;
        end
        #2;
    endtask

    task automatic access(input mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be);
        present(op, addr, wdata, be);
        wait_accept();
        req_valid = 1'b0;
        wait_response();
        if (op == MEM_STORE) begin
            ref_store(addr, wdata, be);
        end
    endtask

    // keep req_valid up with junk while busy, then hold the next store until taken
    task automatic hold_while_busy(input logic [31:0] addr, input logic [31:0] wdata);
        int unsigned r;
        present(MEM_STORE, addr, 32'hcafe_f00d, 4'b1111);
        wait_accept();
        repeat (RSP_LATENCY) begin
            r           = $urandom();
            req.op      = mem_op_e'(r[8]);
            req.addr    = r & 32'h0000_00fc;
            req.wdata   = $urandom();
            req.byte_en = r[3:0];
            @(posedge clk);
            #2;
        end
        ref_store(addr, 32'hcafe_f00d, 4'b1111);
        // first store still outstanding here
        present(MEM_STORE, addr + 32'd4, wdata, 4'b1111);
        wait_accept();
        req_valid = 1'b0;
        wait_response();
        ref_store(addr + 32'd4, wdata, 4'b1111);
        access(MEM_LOAD, addr, 32'h0, 4'b1111);
        access(MEM_LOAD, addr + 32'd4, 32'h0, 4'b1111);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, a request or response never completed", cycle_cnt);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int unsigned r;
        logic [31:0] base;
        logic [3:0]  be;
        void'($urandom(11));
        nrst      = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        errors    = 0;
        issue_cnt = 0;
        exp_load  = 1'b0;
        exp_rdata = '0;
        for (int i = 0; i < MEM_WORDS * 4; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        #2 nrst = 1'b1;
        @(posedge clk);
        #2;

        // untouched words read back as zero
        for (int i = 0; i < 4; i++) begin
            access(MEM_LOAD, 32'(i * 16), 32'h0, 4'b1111);
        end

        access(MEM_STORE, 32'h20, 32'h1234_5678, 4'b1111);
        access(MEM_LOAD, 32'h20, 32'h0, 4'b1111);
        access(MEM_STORE, 32'h24, 32'hdead_beef, 4'b1111);
        access(MEM_LOAD, 32'h24, 32'h0, 4'b1111);

        // partial stores at the lowest enabled offset
        access(MEM_STORE, 32'h21, 32'h0000_a500, 4'b0010);
        access(MEM_LOAD, 32'h20, 32'h0, 4'b1111);
        access(MEM_STORE, 32'h26, 32'h5a3c_0000, 4'b1100);
        access(MEM_LOAD, 32'h24, 32'h0, 4'b1111);

        for (int i = 0; i < 40; i++) begin
            r    = $urandom();
            base = 32'((r % MEM_WORDS) * 4);
            case (r[31:29] % 7)
                0: be = 4'b1111;
                1: be = 4'b0011;
                2: be = 4'b1100;
                3: be = 4'b0001;
                4: be = 4'b0010;
                5: be = 4'b0100;
                default: be = 4'b1000;
            endcase
            access(MEM_STORE, base + 32'(low_offset(be)), $urandom(), be);
            access(MEM_LOAD, base, 32'h0, 4'b1111);
        end

        // holes in the enables must not write
        access(MEM_STORE, 32'h20, 32'hffff_ffff, 4'b0101);
        access(MEM_LOAD, 32'h20, 32'h0, 4'b1111);
        access(MEM_STORE, 32'h25, 32'hffff_ffff, 4'b0110);
        access(MEM_LOAD, 32'h24, 32'h0, 4'b1111);

        hold_while_busy(32'h40, 32'h0bad_cafe);

        if (acc_cnt != issue_cnt) begin
            errors++;
            $display("the DUT accepted %0d requests but %0d were issued", acc_cnt, issue_cnt);
        end
        $display("checks failed: %0d, requests issued: %0d", errors, issue_cnt);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* piton_mem_subsys.f */
rtl/piton_pkg.sv
rtl/core_mem_pkg.sv
rtl/core_piton.sv
rtl/l15_mem_model.sv
rtl/piton_mem_subsys.sv
verification/tb_piton_mem_subsys.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_piton_mem_subsys -Mdir obj_dir -f piton_mem_subsys.f
	@out="$$(./obj_dir/Vtb_piton_mem_subsys)"; echo "$$out"; \
		echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
